//--- verilog/aluOpPkg.sv
// Operation codes of the execution unit and helpers that classify them
// Imported by the decoder side of aluExecute and by both datapath units
`default_nettype none

package aluOpPkg;

   // Encoding order matters to the test vectors, which give the index
   typedef enum logic [4:0] {
      opAdd, opAddc, opRsub, opRsubc, opCmp, opCmpu,
      opOr, opAnd, opXor, opAndn,
      opSra, opSrc, opSrl, opSext8, opSext16,
      opBsrl, opBsra, opBsll
   } aluOp_t;

   // Result comes from the adder
   function automatic logic isAddClass(aluOp_t op);
      return op inside {opAdd, opAddc, opRsub, opRsubc, opCmp, opCmpu};
   endfunction

   // Result comes from the shift and logic unit
   function automatic logic isShiftLogicClass(aluOp_t op);
      return !isAddClass(op);
   endfunction

   // Compares and logic leave the flag alone
   function automatic logic updatesCarry(aluOp_t op);
      return op inside {opAdd, opAddc, opRsub, opRsubc, opSra, opSrc, opSrl};
   endfunction

endpackage

`default_nettype wire

//--- verilog/aluDataPkg.sv
// Data types carried through the execution unit and its result queue
`default_nettype none

package aluDataPkg;

   localparam int DataWidth  = 32;
   localparam int ShamtWidth = $clog2(DataWidth); // 5 for a 32-bit word

   typedef logic [DataWidth-1:0]  word_t;
   typedef logic [ShamtWidth-1:0] shamt_t;  // Barrel shift amount

   // One queue entry, 33 bits
   typedef struct packed {
      word_t result;
      logic  carry;  // Flag value after the operation
   } aluResult_t;

endpackage

`default_nettype wire

//--- verilog/addCompareUnit.sv
// Combinational adder for add, reverse subtract and compare operations
// Computes B + A or B + ~A with the carry-in chosen by the operation
`timescale 1ns/1ps
`default_nettype none

module addCompareUnit
   import aluOpPkg::*;
   import aluDataPkg::*;
(
   input  aluOp_t op_i,
   input  word_t  opA_i,
   input  word_t  opB_i,
   input  logic   carry_i,    // Current flag
   output word_t  sum_o,
   output logic   carryOut_o
);

   logic  invertA;
   logic  carryIn;
   word_t addendA;
   word_t rawSum;
   logic  rawCarry;
   logic  gtSigned;
   logic  gtUnsigned;

   // Reverse subtract and compare take B - A
   assign invertA = op_i inside {opRsub, opRsubc, opCmp, opCmpu};
   assign addendA = invertA ? ~opA_i : opA_i;

   always_comb begin
      case (op_i)
         opAddc, opRsubc:     carryIn = carry_i;  // With-carry forms
         opRsub, opCmp, opCmpu: carryIn = 1'b1;   // Two's complement +1
         default:             carryIn = 1'b0;
      endcase
   end

   assign {rawCarry, rawSum} = {1'b0, opB_i} + {1'b0, addendA} + (DataWidth+1)'(carryIn);

   assign gtSigned   = $signed(opA_i) > $signed(opB_i);
   assign gtUnsigned = opA_i > opB_i;

   // Compares overwrite the sign bit with the order flag
   always_comb begin
      case (op_i)
         opCmp:   sum_o = {gtSigned, rawSum[DataWidth-2:0]};
         opCmpu:  sum_o = {gtUnsigned, rawSum[DataWidth-2:0]};
         default: sum_o = rawSum;
      endcase
   end

   assign carryOut_o = rawCarry;

endmodule

`default_nettype wire

//--- verilog/shiftLogicUnit.sv
// Combinational logic ops, single-bit shifts, sign extension, barrel shifts
// All shifts act on operand A; the barrel amount is B's low bits
`timescale 1ns/1ps
`default_nettype none

module shiftLogicUnit
   import aluOpPkg::*;
   import aluDataPkg::*;
(
   input  aluOp_t op_i,
   input  word_t  opA_i,
   input  word_t  opB_i,
   input  logic   carry_i,      // Fill bit for opSrc
   output word_t  result_o,
   output logic   shiftCarry_o
);

   shamt_t shamt;
   word_t  barrelSra;

   assign shamt = opB_i[ShamtWidth-1:0];  // Upper B bits ignored

   // Arithmetic right keeps the sign
   assign barrelSra = word_t'($signed(opA_i) >>> shamt);

   always_comb begin
      case (op_i)
         // Logic
         opOr:     result_o = opA_i | opB_i;
         opAnd:    result_o = opA_i & opB_i;
         opXor:    result_o = opA_i ^ opB_i;
         opAndn:   result_o = opA_i & ~opB_i;

         // Single right shifts, differing only in the fill bit
         opSra:    result_o = {opA_i[DataWidth-1], opA_i[DataWidth-1:1]};
         opSrc:    result_o = {carry_i, opA_i[DataWidth-1:1]};
         opSrl:    result_o = {1'b0, opA_i[DataWidth-1:1]};

         // Sign extension
         opSext8:  result_o = {{(DataWidth-8){opA_i[7]}}, opA_i[7:0]};
         opSext16: result_o = {{(DataWidth-16){opA_i[15]}}, opA_i[15:0]};

         // Barrel
         opBsrl:   result_o = opA_i >> shamt;
         opBsra:   result_o = barrelSra;
         opBsll:   result_o = opA_i << shamt;

         default:  result_o = '0;  // Adder ops, result unused
      endcase
   end

   // Bit shifted out by the single shifts
   assign shiftCarry_o = opA_i[0];

endmodule

`default_nettype wire

//--- verilog/aluExecute.sv
// Accepts operations over the four-phase input link and pushes results
// Owns the carry flag; one operation per handshake, executed in order
`timescale 1ns/1ps
`default_nettype none

module aluExecute
   import aluOpPkg::*;
   import aluDataPkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,

   // Input link
   input  logic       opReq_i,
   output logic       opAck_o,
   input  aluOp_t     op_i,
   input  word_t      opA_i,
   input  word_t      opB_i,

   // Queue push side
   input  logic       full_i,
   output logic       push_o,
   output aluResult_t pushData_o
);

   logic  accept;
   logic  carryQ;      // Architectural carry flag
   logic  nextCarry;
   word_t addSum;
   logic  addCarry;
   word_t slResult;
   logic  slCarry;
   word_t resultWord;

   addCompareUnit u_addCompare (
      .op_i       (op_i),
      .opA_i      (opA_i),
      .opB_i      (opB_i),
      .carry_i    (carryQ),
      .sum_o      (addSum),
      .carryOut_o (addCarry)
   );

   shiftLogicUnit u_shiftLogic (
      .op_i         (op_i),
      .opA_i        (opA_i),
      .opB_i        (opB_i),
      .carry_i      (carryQ),
      .result_o     (slResult),
      .shiftCarry_o (slCarry)
   );

   // New request, previous ack already dropped, room in the queue
   assign accept = opReq_i & ~opAck_o & ~full_i;

   always_comb begin
      nextCarry = carryQ;  // Kept by compares, logic, sext, barrel
      if (updatesCarry(op_i)) begin
         nextCarry = isShiftLogicClass(op_i) ? slCarry : addCarry;
      end
   end

   assign resultWord = isAddClass(op_i) ? addSum : slResult;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         opAck_o <= 1'b0;
         carryQ  <= 1'b0;
      end else if (accept) begin
         opAck_o <= 1'b1;
         carryQ  <= nextCarry;
      end else if (!opReq_i) begin
         opAck_o <= 1'b0;  // Return to zero
      end
   end

   // Push happens at the accepting edge
   assign push_o     = accept;
   assign pushData_o = {resultWord, nextCarry};

   // Requester holds the request and its operands until the ack rises
   opsStableUntilAck: assert property (@(posedge clk_i) disable iff (rst_i)
      opReq_i && !opAck_o |=>
         opReq_i && $stable(op_i) && $stable(opA_i) && $stable(opB_i))
      else $error("opReq_i or its operands changed before opAck_o rose");

endmodule

`default_nettype wire

//--- verilog/resultQueue.sv
// Synchronous circular-buffer FIFO for execution results
// Depth must be a power of two; push and pop may share a cycle
`timescale 1ns/1ps
`default_nettype none

module resultQueue
   import aluDataPkg::*;
#(
   parameter int QueueDepth = 4
) (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       push_i,
   input  aluResult_t pushData_i,
   output logic       full_o,
   input  logic       pop_i,
   output logic       empty_o,
   output aluResult_t headData_o
);

   localparam int PtrWidth = $clog2(QueueDepth);

   aluResult_t           storage [QueueDepth];
   logic [PtrWidth-1:0]  wrPtr;
   logic [PtrWidth-1:0]  rdPtr;
   logic [PtrWidth:0]    count;  // One extra bit to hold QueueDepth

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         storage[wrPtr] <= pushData_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push_i) wrPtr <= wrPtr + 1'b1;  // Wraps at depth
         if (pop_i)  rdPtr <= rdPtr + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   assign full_o     = (count == (PtrWidth+1)'(QueueDepth));
   assign empty_o    = (count == '0);
   assign headData_o = storage[rdPtr];  // Valid one cycle after push

   noPushWhenFull: assert property (@(posedge clk_i) disable iff (rst_i)
      push_i |-> !full_o)
      else $error("push into full result queue");

   noPopWhenEmpty: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> !empty_o)
      else $error("pop from empty result queue");

endmodule

`default_nettype wire

//--- verilog/resultSender.sv
// Drains the result queue over the four-phase output link
// Loads the head into an output register and pops it in the same edge
`timescale 1ns/1ps
`default_nettype none

module resultSender
   import aluDataPkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       empty_i,
   input  aluResult_t headData_i,
   output logic       pop_o,
   output logic       resReq_o,
   input  logic       resAck_i,
   output word_t      result_o,
   output logic       carry_o
);

   typedef enum logic [1:0] {
      SendIdle,     // Waiting for a queued result
      SendReq,      // resReq_o high, waiting for ack
      SendWaitLow   // Waiting for ack to return to zero
   } sendState_t;

   sendState_t state;

   assign pop_o = (state == SendIdle) & ~empty_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= SendIdle;
      end else begin
         case (state)
            SendIdle:    if (!empty_i) state <= SendReq;
            SendReq:     if (resAck_i) state <= SendWaitLow;
            SendWaitLow: if (!resAck_i) state <= SendIdle;
            default:     state <= SendIdle;
         endcase
      end
   end

   // Output register, stable for the whole transfer
   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         result_o <= headData_i.result;
         carry_o  <= headData_i.carry;
      end
   end

   assign resReq_o = (state == SendReq);

   // Receiver acks only a pending request
   ackOnlyWithReq: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(resAck_i) |-> resReq_o)
      else $error("resAck_i rose while resReq_o was low");

endmodule

`default_nettype wire

//--- verilog/aluTop.sv
// Standalone execution unit: input link, result queue, output link
// Sets the queue depth; instances and wiring only
`timescale 1ns/1ps
`default_nettype none

module aluTop
   import aluOpPkg::*;
   import aluDataPkg::*;
#(
   parameter int QueueDepth = 4  // Power of two, 2 or more
) (
   input  logic   clk_i,
   input  logic   rst_i,

   // Operation link
   input  logic   opReq_i,
   output logic   opAck_o,
   input  aluOp_t op_i,
   input  word_t  opA_i,
   input  word_t  opB_i,

   // Result link
   output logic   resReq_o,
   input  logic   resAck_i,
   output word_t  result_o,
   output logic   carry_o
);

   logic       queueFull;
   logic       queuePush;
   logic       queueEmpty;
   logic       queuePop;
   aluResult_t pushData;
   aluResult_t headData;

   aluExecute u_execute (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .opReq_i    (opReq_i),
      .opAck_o    (opAck_o),
      .op_i       (op_i),
      .opA_i      (opA_i),
      .opB_i      (opB_i),
      .full_i     (queueFull),
      .push_o     (queuePush),
      .pushData_o (pushData)
   );

   resultQueue #(
      .QueueDepth (QueueDepth)
   ) u_queue (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .push_i     (queuePush),
      .pushData_i (pushData),
      .full_o     (queueFull),
      .pop_i      (queuePop),
      .empty_o    (queueEmpty),
      .headData_o (headData)
   );

   resultSender u_sender (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .empty_i    (queueEmpty),
      .headData_i (headData),
      .pop_o      (queuePop),
      .resReq_o   (resReq_o),
      .resAck_i   (resAck_i),
      .result_o   (result_o),
      .carry_o    (carry_o)
   );

endmodule

`default_nettype wire

//--- tb/aluTb.sv
// Testbench for aluTop, replaying vectors from tb/alu_testdata.txt over both links
// Top module aluTb; compile with src.f from the project root
`timescale 1ns/1ps
`default_nettype none

module aluTb
   import aluOpPkg::*;
   import aluDataPkg::*;
();

   localparam int QueueDepth  = 4;
   localparam int Capacity    = QueueDepth + 1;  // Queue entries plus sender output register
   localparam int StallWindow = 16;              // Cycles watched for a wrongly accepted request
   localparam int MaxVectors  = 64;

   logic   clk_i;
   logic   rst_i;
   logic   opReq_i;
   logic   opAck_o;
   aluOp_t op_i;
   word_t  opA_i;
   word_t  opB_i;
   logic   resReq_o;
   logic   resAck_i;
   word_t  result_o;
   logic   carry_o;

   // Vector table
   aluOp_t vecOp     [MaxVectors];
   word_t  vecA      [MaxVectors];
   word_t  vecB      [MaxVectors];
   word_t  vecResult [MaxVectors];
   logic   vecCarry  [MaxVectors];
   int     numVectors;

   int     valueErrors;
   int     otherErrors;   // Protocol, file and ordering problems
   int     acceptedCount; // Requests acknowledged so far
   int     receivedCount; // Results taken so far
   int     cycleCount;
   int     cycleLimit;    // 0 until the vectors are known
   integer seed;

   aluTop #(
      .QueueDepth (QueueDepth)
   ) u_dut (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .opReq_i  (opReq_i),
      .opAck_o  (opAck_o),
      .op_i     (op_i),
      .opA_i    (opA_i),
      .opB_i    (opB_i),
      .resReq_o (resReq_o),
      .resAck_i (resAck_i),
      .result_o (result_o),
      .carry_o  (carry_o)
   );

   always #5 clk_i = ~clk_i;  // 10 ns period

   // Watchdog
   always @(posedge clk_i) begin
      cycleCount <= cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles with %0d of %0d results received",
                  cycleCount, receivedCount, numVectors);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic compareWord(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         valueErrors++;
         $display("FAILED %s result: expected %08h, actual %08h", name, expected, actual);
      end
   endtask

   task automatic compareCarry(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         valueErrors++;
         $display("FAILED %s carry: expected %0b, actual %0b", name, expected, actual);
      end
   endtask

   // Lines starting with # and blank lines are skipped
   task automatic readVectors();
      int    fd;
      int    code;
      int    fields;
      int    opIdx;
      string line;
      word_t a;
      word_t b;
      word_t r;
      logic  c;
      fd = $fopen("tb/alu_testdata.txt", "r");
      if (fd == 0) begin
         otherErrors++;
         $display("Cannot open tb/alu_testdata.txt");
         return;
      end
      code = $fgets(line, fd);
      while (code != 0) begin
         if (line.len() > 4 && line.getc(0) != "#") begin
            fields = $sscanf(line, "%d %h %h %h %h", opIdx, a, b, r, c);
            if (fields == 5 && opIdx >= 0 && opIdx <= 17 && numVectors < MaxVectors) begin
               vecOp[numVectors]     = aluOp_t'(opIdx);
               vecA[numVectors]      = a;
               vecB[numVectors]      = b;
               vecResult[numVectors] = r;
               vecCarry[numVectors]  = c;
               numVectors++;
            end else begin
               otherErrors++;
               $display("Bad or excess line in test data: %s", line);
            end
         end
         code = $fgets(line, fd);
      end
      $fclose(fd);
      if (numVectors == 0) begin
         otherErrors++;
         $display("No test vectors were read");
      end
   endtask

   // Four-phase input side, one request at a time
   task automatic driveOps();
      int i;
      int gap;
      for (i = 0; i < numVectors; i++) begin
         @(posedge clk_i);
         opReq_i <= 1'b1;
         op_i    <= vecOp[i];
         opA_i   <= vecA[i];
         opB_i   <= vecB[i];
         do @(negedge clk_i); while (opAck_o !== 1'b1);
         acceptedCount++;
         @(posedge clk_i);
         opReq_i <= 1'b0;
         do @(negedge clk_i); while (opAck_o !== 1'b0);
         gap = (i * 3) % 4;  // 0 to 3 idle cycles
         repeat (gap) @(posedge clk_i);
      end
   endtask

   // First result held back until the DUT can take no more
   task automatic checkBackPressure();
      while (acceptedCount < Capacity && acceptedCount < numVectors) begin
         @(negedge clk_i);
      end
      repeat (StallWindow) @(negedge clk_i);
      if (numVectors > Capacity) begin
         if (acceptedCount != Capacity) begin
            otherErrors++;
            $display("Request accepted while the result queue was full (%0d accepted)",
                     acceptedCount);
         end
         if (!(opReq_i && !opAck_o)) begin
            otherErrors++;
            $display("No request was left waiting while results were held back");
         end
      end
   endtask

   // Four-phase output side with random ack delay
   task automatic collectResults();
      int    delay;
      string name;
      while (receivedCount < numVectors) begin
         do @(negedge clk_i); while (resReq_o !== 1'b1);
         if (receivedCount == 0) begin
            checkBackPressure();
         end
         name = $sformatf("vector %0d %s", receivedCount, vecOp[receivedCount].name());
         compareWord(name, vecResult[receivedCount], result_o);
         compareCarry(name, vecCarry[receivedCount], carry_o);
         delay = {$random(seed)} % 8;
         repeat (delay) @(posedge clk_i);
         @(posedge clk_i);
         resAck_i <= 1'b1;
         do @(negedge clk_i); while (resReq_o !== 1'b0);
         @(posedge clk_i);
         resAck_i <= 1'b0;
         receivedCount++;
      end
   endtask

   initial begin
      clk_i         = 1'b0;
      rst_i         = 1'b1;
      opReq_i       = 1'b0;
      op_i          = opAdd;
      opA_i         = '0;
      opB_i         = '0;
      resAck_i      = 1'b0;
      seed          = 80700;
      numVectors    = 0;
      valueErrors   = 0;
      otherErrors   = 0;
      acceptedCount = 0;
      receivedCount = 0;
      cycleCount    = 0;
      cycleLimit    = 0;
      readVectors();
      cycleLimit = numVectors * 20 + 100;  // Includes reset and the stall window
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b0;
      fork
         driveOps();
         collectResults();
      join
      repeat (2) @(posedge clk_i);
      $display("Summary: %0d vectors, %0d results, %0d value errors, %0d other errors",
               numVectors, receivedCount, valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/alu_testdata.txt
# op index (decimal), A, B, expected result, expected carry (hex)
# carry is the running flag after the operation, so line order matters
0  FFFFFFFF 00000001 00000000 1
1  00000001 00000002 00000004 0
2  12345678 12345678 00000000 1
3  00000005 00000010 0000000B 1
3  00000003 00000001 FFFFFFFE 0
3  00000001 00000003 00000001 1
4  80000000 00000001 00000001 1
5  80000000 00000001 80000001 1
6  F0F0F0F0 0F0F00FF FFFFF0FF 1
7  F0F0F0F0 FF00FF00 F000F000 1
8  AAAA5555 FFFF0000 55555555 1
9  12345678 0000FFFF 12340000 1
13 12345680 00000000 FFFFFF80 1
14 ABCD8001 00000000 FFFF8001 1
10 80000003 00000000 C0000001 1
11 00000002 00000000 80000001 0
11 00000005 00000000 00000002 1
12 FFFFFFFE 00000000 7FFFFFFF 0
15 80000000 0000001F 00000001 0
15 12345678 00000000 12345678 0
16 80000000 00000001 C0000000 0
16 80000000 0000001F FFFFFFFF 0
17 00000001 FFFFFFE4 00000010 0
17 00000003 0000001F 80000000 0
15 F0000000 00000021 78000000 0

//--- src.f
verilog/aluOpPkg.sv
verilog/aluDataPkg.sv
verilog/addCompareUnit.sv
verilog/shiftLogicUnit.sv
verilog/aluExecute.sv
verilog/resultQueue.sv
verilog/resultSender.sv
verilog/aluTop.sv
tb/aluTb.sv

//--- Bender.yml
package:
  name: aluExec

sources:
  - verilog/aluOpPkg.sv
  - verilog/aluDataPkg.sv
  - verilog/addCompareUnit.sv
  - verilog/shiftLogicUnit.sv
  - verilog/aluExecute.sv
  - verilog/resultQueue.sv
  - verilog/resultSender.sv
  - verilog/aluTop.sv
  - target: simulation
    files:
      - tb/aluTb.sv
